//--- rtl/loader_pkg.sv
////////////////////////////////////////
// Serial loader shared types
////////////////////////////////////////

package loader_pkg;

    typedef logic [7:0] byte_t;

    // command bytes sent by the host
    typedef enum logic [7:0] {
        op_write = 8'h57,  // 'W'
        op_read  = 8'h52   // 'R'
    } opcode_e;

    typedef enum logic [2:0] {
        st_opcode,
        st_addr_hi,
        st_addr_lo,
        st_len,
        st_payload,
        st_wait      // command pending or read reply running
    } decode_state_e;

    typedef struct packed {
        opcode_e     opcode;
        logic [15:0] addr;
        byte_t       len;
    } cmd_t;

    typedef struct packed {
        logic        write;
        logic [15:0] addr;  // ram decodes the low bits only
        byte_t       data;
    } mem_req_t;

endpackage

//--- rtl/uart_rx.sv
////////////////////////////////////////
// UART receiver, 8N1
////////////////////////////////////////

module uart_rx #(
    parameter int clks_per_bit = 16
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              rx,
    output loader_pkg::byte_t rx_data,
    output logic              rx_valid
);
    import loader_pkg::*;

    localparam int cnt_w = $clog2(clks_per_bit);

    typedef enum logic [1:0] {rx_idle, rx_start_bit, rx_bits, rx_stop_bit} rx_state_e;

    rx_state_e        state;
    logic             rx_meta;
    logic             rx_sync;
    logic [cnt_w-1:0] baud_cnt;
    logic [2:0]       bit_idx;
    byte_t            shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            state    <= rx_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_meta  <= rx;
            rx_sync  <= rx_meta;
            rx_valid <= 1'b0;
            baud_cnt <= baud_cnt + 1'b1;
            case (state)
                rx_idle: begin
                    baud_cnt <= '0;
                    if (!rx_sync) state <= rx_start_bit;  // falling edge
                end
                rx_start_bit: begin
                    if (baud_cnt == cnt_w'(clks_per_bit / 2 - 1)) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_sync ? rx_idle : rx_bits;  // glitch check
                    end
                end
                rx_bits: begin
                    if (baud_cnt == cnt_w'(clks_per_bit - 1)) begin
                        baud_cnt <= '0;
                        shift    <= {rx_sync, shift[7:1]};  // lsb first
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= rx_stop_bit;
                    end
                end
                default: begin
                    if (baud_cnt == cnt_w'(clks_per_bit - 1)) begin
                        if (rx_sync) begin
                            rx_data  <= shift;
                            rx_valid <= 1'b1;
                        end
                        state <= rx_idle;  // bad stop bit drops the byte
                    end
                end
            endcase
        end
    end

endmodule

//--- rtl/uart_tx.sv
////////////////////////////////////////
// UART transmitter, 8N1
////////////////////////////////////////

module uart_tx #(
    parameter int clks_per_bit = 16
) (
    input  logic              clk,
    input  logic              reset,
    input  loader_pkg::byte_t tx_data,
    input  logic              tx_start,
    output logic              tx,
    output logic              tx_busy
);

    localparam int cnt_w = $clog2(clks_per_bit);

    logic [cnt_w-1:0] baud_cnt;
    logic [3:0]       bit_cnt;  // 0 is the start bit, 9 the stop bit
    logic [8:0]       shift;    // data bits then stop bit

    always_ff @(posedge clk) begin
        if (reset) begin
            tx       <= 1'b1;
            tx_busy  <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                shift    <= {1'b1, tx_data};
                tx       <= 1'b0;
                tx_busy  <= 1'b1;
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (baud_cnt == cnt_w'(clks_per_bit - 1)) begin
            baud_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                tx_busy <= 1'b0;  // stop bit finished
            end else begin
                tx      <= shift[0];
                shift   <= {1'b1, shift[8:1]};
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

//--- rtl/loader_decode.sv
////////////////////////////////////////
// Command header parser
////////////////////////////////////////

module loader_decode (
    input  logic              clk,
    input  logic              reset,
    input  loader_pkg::byte_t rx_data,
    input  logic              rx_valid,
    output loader_pkg::cmd_t  cmd,
    output logic              cmd_valid,
    input  logic              cmd_ready,
    output loader_pkg::byte_t wr_data,
    output logic              wr_valid,
    input  logic              exec_busy
);
    import loader_pkg::*;

    decode_state_e state;
    byte_t         pay_cnt;   // payload bytes still to come
    logic          op_known;

    assign op_known = (cmd.opcode == op_write) || (cmd.opcode == op_read);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_opcode;
            cmd_valid <= 1'b0;
            wr_valid  <= 1'b0;
            pay_cnt   <= '0;
        end else begin
            wr_valid <= 1'b0;
            case (state)
                st_opcode: begin
                    if (rx_valid) begin
                        cmd.opcode <= opcode_e'(rx_data);
                        state      <= st_addr_hi;
                    end
                end
                st_addr_hi: begin
                    if (rx_valid) begin
                        cmd.addr[15:8] <= rx_data;
                        state          <= st_addr_lo;
                    end
                end
                st_addr_lo: begin
                    if (rx_valid) begin
                        cmd.addr[7:0] <= rx_data;
                        state         <= st_len;
                    end
                end
                st_len: begin
                    if (rx_valid) begin
                        cmd.len <= rx_data;
                        pay_cnt <= rx_data;
                        if (op_known && rx_data != 8'd0) begin
                            cmd_valid <= 1'b1;
                            state     <= st_wait;
                        end else begin
                            state <= st_opcode;  // header dropped
                        end
                    end
                end
                st_wait: begin
                    if (cmd_valid) begin
                        if (cmd_ready) begin
                            cmd_valid <= 1'b0;
                            if (cmd.opcode == op_write) state <= st_payload;
                        end
                    end else if (!exec_busy) begin
                        state <= st_opcode;  // read reply done
                    end
                end
                st_payload: begin
                    if (rx_valid) begin
                        wr_data  <= rx_data;
                        wr_valid <= 1'b1;
                        pay_cnt  <= pay_cnt - 1'b1;
                        if (pay_cnt == 8'd1) state <= st_opcode;
                    end
                end
                default: state <= st_opcode;
            endcase
        end
    end

endmodule

//--- rtl/loader_execute.sv
////////////////////////////////////////
// Memory access sequencer
////////////////////////////////////////

module loader_execute #(
    parameter int addr_width = 10
) (
    input  logic                 clk,
    input  logic                 reset,
    input  loader_pkg::cmd_t     cmd,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    input  loader_pkg::byte_t    wr_data,
    input  logic                 wr_valid,
    output logic                 exec_busy,
    output loader_pkg::mem_req_t mem_req,
    output logic                 mem_en,
    input  loader_pkg::byte_t    mem_rdata,
    output loader_pkg::byte_t    rd_data,
    output logic                 rd_valid,
    input  logic                 rd_ready
);
    import loader_pkg::*;

    typedef enum logic [2:0] {
        ex_idle,
        ex_write,
        ex_rd_mem,      // ram read in progress
        ex_rd_capture,
        ex_rd_hold      // waiting for result to take the byte
    } exec_state_e;

    exec_state_e           state;
    logic [addr_width-1:0] addr_ptr;   // wraps inside the ram
    byte_t                 remaining;

    assign cmd_ready = (state == ex_idle);
    assign exec_busy = (state != ex_idle);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ex_idle;
            mem_en    <= 1'b0;
            rd_valid  <= 1'b0;
            addr_ptr  <= '0;
            remaining <= '0;
        end else begin
            mem_en <= 1'b0;
            case (state)
                ex_idle: begin
                    remaining <= cmd.len;
                    if (cmd_valid && cmd.opcode == op_read) begin
                        mem_en   <= 1'b1;
                        mem_req  <= '{write: 1'b0, addr: cmd.addr, data: '0};
                        addr_ptr <= cmd.addr[addr_width-1:0] + 1'b1;
                        state    <= ex_rd_mem;
                    end else if (cmd_valid) begin
                        addr_ptr <= cmd.addr[addr_width-1:0];
                        state    <= ex_write;
                    end
                end
                ex_write: begin
                    if (wr_valid) begin
                        mem_en    <= 1'b1;
                        mem_req   <= '{write: 1'b1, addr: 16'(addr_ptr), data: wr_data};
                        addr_ptr  <= addr_ptr + 1'b1;
                        remaining <= remaining - 1'b1;
                        if (remaining == 8'd1) state <= ex_idle;
                    end
                end
                ex_rd_mem: state <= ex_rd_capture;
                ex_rd_capture: begin
                    rd_data  <= mem_rdata;
                    rd_valid <= 1'b1;
                    state    <= ex_rd_hold;
                end
                default: begin
                    if (rd_ready) begin
                        rd_valid  <= 1'b0;
                        remaining <= remaining - 1'b1;
                        if (remaining == 8'd1) begin
                            state <= ex_idle;
                        end else begin
                            mem_en   <= 1'b1;  // next byte
                            mem_req  <= '{write: 1'b0, addr: 16'(addr_ptr), data: '0};
                            addr_ptr <= addr_ptr + 1'b1;
                            state    <= ex_rd_mem;
                        end
                    end
                end
            endcase
        end
    end

endmodule

//--- rtl/loader_result.sv
////////////////////////////////////////
// Read reply buffer
////////////////////////////////////////

module loader_result (
    input  logic              clk,
    input  logic              reset,
    input  loader_pkg::byte_t rd_data,
    input  logic              rd_valid,
    output logic              rd_ready,
    output loader_pkg::byte_t tx_data,
    output logic              tx_start,
    input  logic              tx_busy
);

    logic full;

    assign rd_ready = !full;
    assign tx_start = full && !tx_busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (tx_start) begin
            full <= 1'b0;  // slot freed as the frame starts
        end else if (rd_valid) begin
            full <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid && rd_ready) tx_data <= rd_data;
    end

endmodule

//--- rtl/block_ram.sv
////////////////////////////////////////
// Single-port byte RAM
////////////////////////////////////////

module block_ram #(
    parameter int addr_width = 10
) (
    input  logic                 clk,
    input  loader_pkg::mem_req_t mem_req,
    input  logic                 mem_en,
    output loader_pkg::byte_t    mem_rdata
);
    import loader_pkg::*;

    byte_t mem [0:2**addr_width-1];

    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_req.write) begin
                mem[mem_req.addr[addr_width-1:0]] <= mem_req.data;
            end else begin
                mem_rdata <= mem[mem_req.addr[addr_width-1:0]];  // one cycle latency
            end
        end
    end

endmodule

//--- rtl/serial_loader_top.sv
////////////////////////////////////////
// Serial memory loader top
////////////////////////////////////////

module serial_loader_top #(
    parameter int clks_per_bit = 16,
    parameter int addr_width   = 10
) (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    output logic tx
);
    import loader_pkg::*;

    byte_t    rx_data;
    logic     rx_valid;
    cmd_t     cmd;
    logic     cmd_valid;
    logic     cmd_ready;
    byte_t    wr_data;
    logic     wr_valid;
    logic     exec_busy;
    mem_req_t mem_req;
    logic     mem_en;
    byte_t    mem_rdata;
    byte_t    rd_data;
    logic     rd_valid;
    logic     rd_ready;
    byte_t    tx_data;
    logic     tx_start;
    logic     tx_busy;

    uart_rx #(
        .clks_per_bit(clks_per_bit)
    ) uart_rx_i (
        .clk     (clk),
        .reset   (reset),
        .rx      (rx),
        .rx_data (rx_data),
        .rx_valid(rx_valid)
    );

    loader_decode loader_decode_i (
        .clk      (clk),
        .reset    (reset),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .cmd      (cmd),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .wr_data  (wr_data),
        .wr_valid (wr_valid),
        .exec_busy(exec_busy)
    );

    loader_execute #(
        .addr_width(addr_width)
    ) loader_execute_i (
        .clk      (clk),
        .reset    (reset),
        .cmd      (cmd),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .wr_data  (wr_data),
        .wr_valid (wr_valid),
        .exec_busy(exec_busy),
        .mem_req  (mem_req),
        .mem_en   (mem_en),
        .mem_rdata(mem_rdata),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .rd_ready (rd_ready)
    );

    block_ram #(
        .addr_width(addr_width)
    ) block_ram_i (
        .clk      (clk),
        .mem_req  (mem_req),
        .mem_en   (mem_en),
        .mem_rdata(mem_rdata)
    );

    loader_result loader_result_i (
        .clk     (clk),
        .reset   (reset),
        .rd_data (rd_data),
        .rd_valid(rd_valid),
        .rd_ready(rd_ready),
        .tx_data (tx_data),
        .tx_start(tx_start),
        .tx_busy (tx_busy)
    );

    uart_tx #(
        .clks_per_bit(clks_per_bit)
    ) uart_tx_i (
        .clk     (clk),
        .reset   (reset),
        .tx_data (tx_data),
        .tx_start(tx_start),
        .tx      (tx),
        .tx_busy (tx_busy)
    );

endmodule

//--- verification/serial_loader_tb.sv
////////////////////////////////////////
// Serial loader testbench
////////////////////////////////////////

module serial_loader_tb;
    import loader_pkg::*;

    localparam int clks_per_bit  = 8;
    localparam int addr_width    = 10;
    localparam int mem_depth     = 1 << addr_width;
    localparam int reply_timeout = 40 * clks_per_bit;  // cycles to wait for a start bit
    localparam int idle_window   = 30 * clks_per_bit;

    logic clk;
    logic reset;
    logic rx;
    logic tx;

    byte_t model   [0:mem_depth-1];  // expected memory contents
    byte_t payload [0:255];
    byte_t reply   [0:255];
    byte_t first   [0:2];

    serial_loader_top #(
        .clks_per_bit(clks_per_bit),
        .addr_width  (addr_width)
    ) serial_loader_top_i (
        .clk  (clk),
        .reset(reset),
        .rx   (rx),
        .tx   (tx)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // the address counts up in the low bits only
    function automatic logic [addr_width-1:0] wrap_addr(logic [15:0] addr);
        return addr[addr_width-1:0];
    endfunction

    task automatic end_with_failure();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_byte(string name, byte_t expected, byte_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%02h actual 0x%02h", name, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic check_state(string name, decode_state_e expected, decode_state_e actual);
        if (actual !== expected) begin
            $display("Error: %s expected decoder state %s actual %s", name,
                     expected.name(), actual.name());
            end_with_failure();
        end
    endtask

    task automatic check_idle(string name);
        int   i;
        logic seen_start;
        seen_start = 1'b0;
        for (i = 0; i < idle_window && !seen_start; i++) begin
            @(negedge clk);
            if (tx !== 1'b1) seen_start = 1'b1;
        end
        if (seen_start) begin
            $display("%s: a start bit appeared on tx although no reply was expected", name);
            end_with_failure();
        end
    endtask

    task automatic send_byte(byte_t data);
        int i;
        rx = 1'b0;  // start bit
        repeat (clks_per_bit) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            rx = data[i];  // lsb first
            repeat (clks_per_bit) @(negedge clk);
        end
        rx = 1'b1;  // stop bit
        repeat (clks_per_bit) @(negedge clk);
    endtask

    task automatic recv_byte(string name, output byte_t data);
        int waited;
        int i;
        waited = 0;
        data   = '0;
        while (tx !== 1'b0 && waited < reply_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (tx !== 1'b0) begin
            $display("%s: no start bit on tx within %0d cycles", name, reply_timeout);
            end_with_failure();
        end else begin
            repeat (clks_per_bit / 2) @(negedge clk);  // middle of the start bit
            if (tx !== 1'b0) begin
                $display("%s: start bit on tx ended too early", name);
                end_with_failure();
            end else begin
                for (i = 0; i < 8; i++) begin
                    repeat (clks_per_bit) @(negedge clk);
                    data[i] = tx;
                end
                repeat (clks_per_bit) @(negedge clk);
                if (tx !== 1'b1) begin
                    $display("%s: stop bit on tx is low", name);
                    end_with_failure();
                end
            end
        end
    endtask

    task automatic send_header(byte_t op, logic [15:0] addr, byte_t len);
        send_byte(op);
        send_byte(addr[15:8]);
        send_byte(addr[7:0]);
        send_byte(len);
    endtask

    task automatic fill_payload(int len);
        int i;
        for (i = 0; i < len; i++) payload[i] = 8'($urandom);
    endtask

    task automatic write_mem(logic [15:0] addr, int len);
        int i;
        send_header(op_write, addr, 8'(len));
        for (i = 0; i < len; i++) begin
            send_byte(payload[i]);
            model[wrap_addr(addr + 16'(i))] = payload[i];
        end
    endtask

    task automatic read_mem(string name, logic [15:0] addr, int len);
        int i;
        send_header(op_read, addr, 8'(len));
        for (i = 0; i < len; i++) recv_byte(name, reply[i]);
    endtask

    task automatic check_reply(string name, logic [15:0] addr, int len);
        int i;
        for (i = 0; i < len; i++) check_byte(name, model[wrap_addr(addr + 16'(i))], reply[i]);
    endtask

    task automatic test_write_read_back();
        string name;
        int    i;
        name = "write_read_back";
        fill_payload(6);
        write_mem(16'h0040, 6);
        read_mem(name, 16'h0040, 6);
        for (i = 0; i < 6; i++) check_byte(name, payload[i], reply[i]);
    endtask

    task automatic test_address_continues();
        string name;
        int    i;
        name = "address_continues";
        fill_payload(3);
        write_mem(16'h0100, 3);
        for (i = 0; i < 3; i++) first[i] = payload[i];
        fill_payload(3);
        write_mem(16'h0103, 3);
        read_mem(name, 16'h0100, 6);
        for (i = 0; i < 3; i++) begin
            check_byte(name, first[i], reply[i]);
            check_byte(name, payload[i], reply[i+3]);
        end
    endtask

    task automatic test_address_wrap();
        string name;
        name = "address_wrap";
        fill_payload(4);
        write_mem(16'h03fe, 4);  // last two bytes land at 0 and 1
        read_mem(name, 16'h0000, 2);
        check_byte(name, payload[2], reply[0]);
        check_byte(name, payload[3], reply[1]);
    endtask

    task automatic test_unknown_opcode();
        string name;
        name = "unknown_opcode";
        send_header(8'h41, 16'h0040, 8'd4);
        check_state(name, st_opcode, serial_loader_top_i.loader_decode_i.state);
        check_idle(name);
        read_mem(name, 16'h0040, 6);
        check_reply(name, 16'h0040, 6);
    endtask

    task automatic test_zero_length();
        string name;
        name = "zero_length";
        send_header(op_read, 16'h0040, 8'd0);
        check_state(name, st_opcode, serial_loader_top_i.loader_decode_i.state);
        check_idle(name);
        send_header(op_write, 16'h0100, 8'd0);
        check_state(name, st_opcode, serial_loader_top_i.loader_decode_i.state);
        read_mem(name, 16'h0100, 6);  // parsed as a fresh command
        check_reply(name, 16'h0100, 6);
    endtask

    initial begin
        void'($urandom(7453));
        reset = 1'b1;
        rx    = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        check_state("after_reset", st_opcode, serial_loader_top_i.loader_decode_i.state);
        check_idle("after_reset");
        test_write_read_back();
        test_address_continues();
        test_address_wrap();
        test_unknown_opcode();
        test_zero_length();
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- files.f
rtl/loader_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/loader_decode.sv
rtl/loader_execute.sv
rtl/loader_result.sv
rtl/block_ram.sv
rtl/serial_loader_top.sv
verification/serial_loader_tb.sv

//--- Makefile
SIM := obj_dir/Vserial_loader_tb

.PHONY: all run lint clean

all: run

$(SIM): files.f $(wildcard rtl/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing -j 0 --top-module serial_loader_tb -f files.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Test completed successfully$$" sim.log

lint:
	verilator --lint-only --timing --top-module serial_loader_top -f files.f

clean:
	rm -rf obj_dir sim.log
